//--- fabric_params.svh
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// mesh size, row 0 sits on the north edge
`define FABRIC_ROWS 2
`define FABRIC_COLS 2

// tile address carried on the config bus
`define TILE_ADDR_WIDTH 8

// cb0 2 + cb1 2 + clb 2 + switch box 16
`define TILE_CFG_WIDTH 22

// byte address, tile index lives in bits [9:2]
`define APB_ADDR_WIDTH 12

`endif

//--- fabric_pkg.sv
`include "fabric_params.svh"

package fabric_pkg;

   typedef enum logic [1:0] {
      CB_TRACK_A = 2'd0,
      CB_TRACK_B = 2'd1,
      CB_ZERO    = 2'd2,
      CB_ONE     = 2'd3
   } cb_sel_e;

   typedef enum logic [1:0] {
      CLB_AND  = 2'd0,
      CLB_OR   = 2'd1,
      CLB_XOR  = 2'd2,
      CLB_NAND = 2'd3
   } clb_op_e;

   typedef enum logic [1:0] {
      SB_ZERO     = 2'd0,
      SB_CLB      = 2'd1,
      SB_STRAIGHT = 2'd2,
      SB_TURN     = 2'd3
   } sb_sel_e;

   // first field is the msb, so left_0 ends up in bits [1:0]
   typedef struct packed {
      sb_sel_e bottom_2;
      sb_sel_e bottom_0;
      sb_sel_e top_3;
      sb_sel_e top_1;
      sb_sel_e right_3;
      sb_sel_e right_1;
      sb_sel_e left_2;
      sb_sel_e left_0;
   } sb_cfg_t;

   typedef struct packed {
      sb_cfg_t sb;   // [21:6]
      clb_op_e op;   // [5:4]
      cb_sel_e cb1;  // [3:2]
      cb_sel_e cb0;  // [1:0]
   } tile_cfg_t;

   typedef struct packed {
      logic                        en;
      logic [`TILE_ADDR_WIDTH-1:0] addr;
      tile_cfg_t                   data;
   } cfg_bus_t;

   typedef struct packed {
      logic                       psel;
      logic                       penable;
      logic                       pwrite;
      logic [`APB_ADDR_WIDTH-1:0] paddr;
      logic [31:0]                pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // two tracks per row or column, bit 2*i is the lower-numbered track
   // west in = left_1/left_3, east in = right_0/right_2
   // north in = top_0/top_2, south in = bottom_1/bottom_3
   typedef struct packed {
      logic [2*`FABRIC_ROWS-1:0] west;
      logic [2*`FABRIC_ROWS-1:0] east;
      logic [2*`FABRIC_COLS-1:0] north;
      logic [2*`FABRIC_COLS-1:0] south;
   } edge_in_t;

   // west out = left_0/left_2, east out = right_1/right_3
   // north out = top_1/top_3, south out = bottom_0/bottom_2
   typedef struct packed {
      logic [2*`FABRIC_ROWS-1:0] west;
      logic [2*`FABRIC_ROWS-1:0] east;
      logic [2*`FABRIC_COLS-1:0] north;
      logic [2*`FABRIC_COLS-1:0] south;
   } edge_out_t;

endpackage

//--- connect_box.sv
`timescale 1ns/10ps

module connect_box (
   input  logic                clk,
   input  logic                reset,
   input  logic                cfg_load,
   input  fabric_pkg::cb_sel_e cfg,
   input  logic                track_a,
   input  logic                track_b,
   output logic                operand
);

   import fabric_pkg::*;

   cb_sel_e sel_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         sel_q <= CB_TRACK_A;
      end else if (cfg_load) begin
         sel_q <= cfg;
      end
   end

   // operand follows the stored select without a register
   always_comb begin
      case (sel_q)
         CB_TRACK_A: operand = track_a;
         CB_TRACK_B: operand = track_b;
         CB_ZERO:    operand = 1'b0;
         default:    operand = 1'b1;
      endcase
   end

endmodule

//--- clb.sv
`timescale 1ns/10ps

module clb (
   input  logic                clk,
   input  logic                reset,
   input  logic                cfg_load,
   input  fabric_pkg::clb_op_e cfg,
   input  logic                a,
   input  logic                b,
   output logic                out
);

   import fabric_pkg::*;

   clb_op_e op_q;
   logic    result;

   always_ff @(posedge clk) begin
      if (reset) begin
         op_q <= CLB_AND;
      end else if (cfg_load) begin
         op_q <= cfg;
      end
   end

   always_comb begin
      case (op_q)
         CLB_AND: result = a & b;
         CLB_OR:  result = a | b;
         CLB_XOR: result = a ^ b;
         default: result = ~(a & b);
      endcase
   end

   // one hop of latency through the logic block
   always_ff @(posedge clk) begin
      if (reset) begin
         out <= 1'b0;
      end else begin
         out <= result;
      end
   end

   // operands come from neighbouring tiles, so an X here means a broken link
   out_known_a: assert property (@(posedge clk) disable iff (reset) !$isunknown(out))
      else $error("clb output unknown");

endmodule

//--- switch_box.sv
`timescale 1ns/10ps

module switch_box (
   input  logic                clk,
   input  logic                reset,
   input  logic                cfg_load,
   input  fabric_pkg::sb_cfg_t cfg,

   output logic                left_0,
   input  logic                left_1,
   output logic                left_2,
   input  logic                left_3,

   input  logic                right_0,
   output logic                right_1,
   input  logic                right_2,
   output logic                right_3,

   input  logic                top_0,
   output logic                top_1,
   input  logic                top_2,
   output logic                top_3,

   output logic                bottom_0,
   input  logic                bottom_1,
   output logic                bottom_2,
   input  logic                bottom_3,

   input  logic                compute
);

   import fabric_pkg::*;

   sb_cfg_t sb_cfg_q;

   function automatic logic route(sb_sel_e sel, logic clb_in, logic straight, logic turn);
      case (sel)
         SB_CLB:      route = clb_in;
         SB_STRAIGHT: route = straight;
         SB_TURN:     route = turn;
         default:     route = 1'b0;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         sb_cfg_q <= '0;
      end else if (cfg_load) begin
         sb_cfg_q <= cfg;
      end
   end

   // every output is a flop, so no combinational path crosses the mesh
   always_ff @(posedge clk) begin
      if (reset) begin
         left_0   <= 1'b0;
         left_2   <= 1'b0;
         right_1  <= 1'b0;
         right_3  <= 1'b0;
         top_1    <= 1'b0;
         top_3    <= 1'b0;
         bottom_0 <= 1'b0;
         bottom_2 <= 1'b0;
      end else begin
         left_0   <= route(sb_cfg_q.left_0, compute, right_0, top_0);
         left_2   <= route(sb_cfg_q.left_2, compute, right_2, top_2);
         right_1  <= route(sb_cfg_q.right_1, compute, left_1, bottom_1);
         right_3  <= route(sb_cfg_q.right_3, compute, left_3, bottom_3);
         top_1    <= route(sb_cfg_q.top_1, compute, bottom_1, left_1);
         top_3    <= route(sb_cfg_q.top_3, compute, bottom_3, left_3);
         bottom_0 <= route(sb_cfg_q.bottom_0, compute, top_0, right_0);  // turn from the right
         bottom_2 <= route(sb_cfg_q.bottom_2, compute, top_2, right_2);
      end
   end

   cfg_known_a: assert property (@(posedge clk) disable iff (reset) !$isunknown(sb_cfg_q))
      else $error("switch box config unknown");

endmodule

//--- pe_tile.sv
`timescale 1ns/10ps
`include "fabric_params.svh"

module pe_tile #(
   parameter logic [`TILE_ADDR_WIDTH-1:0] ADDRESS = '0
) (
   input  logic                 clk,
   input  logic                 reset,
   input  fabric_pkg::cfg_bus_t cfg_bus,

   output logic                 left_0,
   input  logic                 left_1,
   output logic                 left_2,
   input  logic                 left_3,

   input  logic                 right_0,
   output logic                 right_1,
   input  logic                 right_2,
   output logic                 right_3,

   input  logic                 top_0,
   output logic                 top_1,
   input  logic                 top_2,
   output logic                 top_3,

   output logic                 bottom_0,
   input  logic                 bottom_1,
   output logic                 bottom_2,
   input  logic                 bottom_3
);

   logic cfg_load;
   logic cb0_out;
   logic cb1_out;
   logic compute_out;

   // single strobe shared by all four blocks
   assign cfg_load = cfg_bus.en && (cfg_bus.addr == ADDRESS);

   connect_box cb0 (
      .clk      (clk),
      .reset    (reset),
      .cfg_load (cfg_load),
      .cfg      (cfg_bus.data.cb0),
      .track_a  (right_0),
      .track_b  (right_2),
      .operand  (cb0_out)
   );

   // bottom inputs, the bottom side's outputs belong to the switch box
   connect_box cb1 (
      .clk      (clk),
      .reset    (reset),
      .cfg_load (cfg_load),
      .cfg      (cfg_bus.data.cb1),
      .track_a  (bottom_1),
      .track_b  (bottom_3),
      .operand  (cb1_out)
   );

   clb compute_block (
      .clk      (clk),
      .reset    (reset),
      .cfg_load (cfg_load),
      .cfg      (cfg_bus.data.op),
      .a        (cb0_out),
      .b        (cb1_out),
      .out      (compute_out)
   );

   switch_box sb (
      .clk      (clk),
      .reset    (reset),
      .cfg_load (cfg_load),
      .cfg      (cfg_bus.data.sb),
      .left_0   (left_0),
      .left_1   (left_1),
      .left_2   (left_2),
      .left_3   (left_3),
      .right_0  (right_0),
      .right_1  (right_1),
      .right_2  (right_2),
      .right_3  (right_3),
      .top_0    (top_0),
      .top_1    (top_1),
      .top_2    (top_2),
      .top_3    (top_3),
      .bottom_0 (bottom_0),
      .bottom_1 (bottom_1),
      .bottom_2 (bottom_2),
      .bottom_3 (bottom_3),
      .compute  (compute_out)
   );

endmodule

//--- config_apb_slave.sv
`timescale 1ns/10ps
`include "fabric_params.svh"

module config_apb_slave (
   input  logic                 clk,
   input  logic                 reset,
   input  fabric_pkg::apb_req_t apb_req,
   output fabric_pkg::apb_rsp_t apb_rsp,
   output fabric_pkg::cfg_bus_t cfg_bus
);

   import fabric_pkg::*;

   localparam int TILES = `FABRIC_ROWS * `FABRIC_COLS;
   localparam int IDX_W = $clog2(TILES);

   logic [`TILE_ADDR_WIDTH-1:0] tile_idx;
   logic                        addr_ok;
   logic                        access;
   logic                        wr_ok;
   tile_cfg_t                   rb_q [TILES];

   assign tile_idx = apb_req.paddr[`TILE_ADDR_WIDTH+1:2];
   assign addr_ok  = (apb_req.paddr[`APB_ADDR_WIDTH-1:`TILE_ADDR_WIDTH+2] == '0)
                     && (tile_idx < `TILE_ADDR_WIDTH'(TILES));
   assign access   = apb_req.psel && apb_req.penable;
   assign wr_ok    = access && apb_req.pwrite && addr_ok;

   always_comb begin
      apb_rsp.pready  = access;  // no wait states
      apb_rsp.pslverr = access && !addr_ok;
      apb_rsp.prdata  = '0;
      if (access && !apb_req.pwrite && addr_ok) begin
         apb_rsp.prdata = 32'(rb_q[tile_idx[IDX_W-1:0]]);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < TILES; i++) begin
            rb_q[i] <= '0;
         end
      end else if (wr_ok) begin
         rb_q[tile_idx[IDX_W-1:0]] <= tile_cfg_t'(apb_req.pwdata[`TILE_CFG_WIDTH-1:0]);
      end
   end

   // en pulses for one cycle after the access, addr and data are held until the next write
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_bus.en <= 1'b0;
      end else begin
         cfg_bus.en <= wr_ok;
      end
      if (wr_ok) begin
         cfg_bus.addr <= tile_idx;
         cfg_bus.data <= tile_cfg_t'(apb_req.pwdata[`TILE_CFG_WIDTH-1:0]);
      end
   end

   penable_needs_psel_a: assert property (
      @(posedge clk) disable iff (reset) $rose(apb_req.penable) |-> apb_req.psel)
      else $error("penable raised without psel");

endmodule

//--- fabric_top.sv
`timescale 1ns/10ps
`include "fabric_params.svh"

module fabric_top (
   input  logic                  clk,
   input  logic                  reset,
   input  fabric_pkg::apb_req_t  apb_req,
   output fabric_pkg::apb_rsp_t  apb_rsp,
   input  fabric_pkg::edge_in_t  edge_in,
   output fabric_pkg::edge_out_t edge_out
);

   import fabric_pkg::*;

   localparam int ROWS = `FABRIC_ROWS;
   localparam int COLS = `FABRIC_COLS;

   cfg_bus_t cfg_bus;

   // per tile side, bit 0 is the lower-numbered track
   logic [1:0] l_in  [ROWS][COLS];
   logic [1:0] l_out [ROWS][COLS];
   logic [1:0] r_in  [ROWS][COLS];
   logic [1:0] r_out [ROWS][COLS];
   logic [1:0] t_in  [ROWS][COLS];
   logic [1:0] t_out [ROWS][COLS];
   logic [1:0] b_in  [ROWS][COLS];
   logic [1:0] b_out [ROWS][COLS];

   logic [2*ROWS-1:0] west_o;
   logic [2*ROWS-1:0] east_o;
   logic [2*COLS-1:0] north_o;
   logic [2*COLS-1:0] south_o;

   config_apb_slave cfg_slave_i (
      .clk     (clk),
      .reset   (reset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .cfg_bus (cfg_bus)
   );

   for (genvar r = 0; r < ROWS; r++) begin : g_row
      for (genvar c = 0; c < COLS; c++) begin : g_col
         if (c == 0) begin : g_west
            assign l_in[r][c]       = edge_in.west[2*r +: 2];
            assign west_o[2*r +: 2] = l_out[r][c];
         end else begin : g_left
            assign l_in[r][c] = r_out[r][c-1];
         end
         if (c == COLS-1) begin : g_east
            assign r_in[r][c]       = edge_in.east[2*r +: 2];
            assign east_o[2*r +: 2] = r_out[r][c];
         end else begin : g_right
            assign r_in[r][c] = l_out[r][c+1];
         end
         if (r == 0) begin : g_north
            assign t_in[r][c]        = edge_in.north[2*c +: 2];
            assign north_o[2*c +: 2] = t_out[r][c];
         end else begin : g_top
            assign t_in[r][c] = b_out[r-1][c];
         end
         if (r == ROWS-1) begin : g_south
            assign b_in[r][c]        = edge_in.south[2*c +: 2];
            assign south_o[2*c +: 2] = b_out[r][c];
         end else begin : g_bottom
            assign b_in[r][c] = t_out[r+1][c];
         end

         pe_tile #(
            .ADDRESS (`TILE_ADDR_WIDTH'(r*COLS + c))  // same index as the apb map
         ) tile_i (
            .clk      (clk),
            .reset    (reset),
            .cfg_bus  (cfg_bus),
            .left_0   (l_out[r][c][0]),
            .left_1   (l_in[r][c][0]),
            .left_2   (l_out[r][c][1]),
            .left_3   (l_in[r][c][1]),
            .right_0  (r_in[r][c][0]),
            .right_1  (r_out[r][c][0]),
            .right_2  (r_in[r][c][1]),
            .right_3  (r_out[r][c][1]),
            .top_0    (t_in[r][c][0]),
            .top_1    (t_out[r][c][0]),
            .top_2    (t_in[r][c][1]),
            .top_3    (t_out[r][c][1]),
            .bottom_0 (b_out[r][c][0]),
            .bottom_1 (b_in[r][c][0]),
            .bottom_2 (b_out[r][c][1]),
            .bottom_3 (b_in[r][c][1])
         );
      end
   end

   assign edge_out = '{west: west_o, east: east_o, north: north_o, south: south_o};

endmodule

//--- tb_fabric.sv
`timescale 1ns/10ps
`include "fabric_params.svh"

module tb_fabric;

   import fabric_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int ROWS       = `FABRIC_ROWS;
   localparam int COLS       = `FABRIC_COLS;
   localparam int TILES      = ROWS * COLS;
   localparam int DIR_HOPS   = 4;    // neighbour switch, clb, tile 0 switch, tile 1 switch
   localparam int RESET_CYC  = 30;
   localparam int REG_CYC    = 60;
   localparam int DIR_CYC    = 340;
   localparam int RAND_CYC   = 420;
   localparam int REWR_CYC   = 100;
   localparam int WATCHDOG_CYCLES = RESET_CYC + REG_CYC + DIR_CYC + RAND_CYC + REWR_CYC + 100;

   logic      clk;
   logic      reset;
   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   edge_in_t  edge_in = '0;
   edge_out_t edge_out;

   integer    seed;
   logic      drive_edges;
   edge_in_t  hist [$];         // every edge input word driven, oldest first

   // cycle model state
   tile_cfg_t m_cfg    [TILES];
   tile_cfg_t m_shadow [TILES];
   logic [1:0] m_l [TILES];     // left_0/left_2
   logic [1:0] m_r [TILES];     // right_1/right_3
   logic [1:0] m_t [TILES];     // top_1/top_3
   logic [1:0] m_b [TILES];     // bottom_0/bottom_2
   logic       m_clb [TILES];
   logic       pend_en;
   int         pend_idx;
   tile_cfg_t  pend_data;

   fabric_top fabric_top_i (
      .clk      (clk),
      .reset    (reset),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .edge_in  (edge_in),
      .edge_out (edge_out)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic logic [`APB_ADDR_WIDTH-1:0] addr_of(input int idx);
      return `APB_ADDR_WIDTH'(idx) << 2;
   endfunction

   function automatic logic [31:0] word_of(input tile_cfg_t cfg);
      return {{(32-`TILE_CFG_WIDTH){1'b0}}, cfg};
   endfunction

   function automatic logic addr_valid(input logic [`APB_ADDR_WIDTH-1:0] a);
      return (a[`APB_ADDR_WIDTH-1:`TILE_ADDR_WIDTH+2] == '0)
             && (int'(a[`TILE_ADDR_WIDTH+1:2]) < TILES);
   endfunction

   function automatic logic cb_pick(input cb_sel_e sel, input logic ta, input logic tb);
      logic [3:0] srcs;
      srcs = {1'b1, 1'b0, tb, ta};
      return srcs[sel];
   endfunction

   function automatic logic sb_pick(input sb_sel_e sel, input logic lb, input logic straight,
                                    input logic turn);
      logic [3:0] srcs;
      srcs = {turn, straight, lb, 1'b0};
      return srcs[sel];
   endfunction

   function automatic logic logic_op(input clb_op_e op, input logic a, input logic b);
      case (op)
         CLB_AND: return a & b;
         CLB_OR:  return a | b;
         CLB_XOR: return a ^ b;
         default: return !(a & b);
      endcase
   endfunction

   // cb0 of tile 0 sees east row 0 via tile 1 and cb1 sees west row 1 via tile 2
   function automatic logic directed_result(input tile_cfg_t cfg, input edge_in_t v);
      logic a;
      logic b;
      a = cb_pick(cfg.cb0, v.east[0], v.east[1]);
      b = cb_pick(cfg.cb1, v.west[2], v.west[3]);
      return logic_op(cfg.op, a, b);
   endfunction

   function automatic edge_out_t model_edge();
      edge_out_t e;
      for (int r = 0; r < ROWS; r++) begin
         e.west[2*r +: 2] = m_l[r*COLS];
         e.east[2*r +: 2] = m_r[r*COLS + COLS-1];
      end
      for (int c = 0; c < COLS; c++) begin
         e.north[2*c +: 2] = m_t[c];
         e.south[2*c +: 2] = m_b[(ROWS-1)*COLS + c];
      end
      return e;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0d ns: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic check_edge(input edge_out_t got, input edge_out_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s: edge_out %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s: prdata %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_slverr(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s: pslverr %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_ready(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s: pready %b, expected %b", what, got, exp));
      end
   endtask

   // setup cycle, one access cycle with no wait states, then idle
   task automatic apb_transfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      @(posedge clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(negedge clk);
      check_ready(apb_rsp.pready, 1'b0, "setup cycle");
      check_slverr(apb_rsp.pslverr, 1'b0, "setup cycle");
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      check_ready(apb_rsp.pready, 1'b1, "access cycle");
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic tile_write(input int idx, input logic [31:0] word);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b1, addr_of(idx), word, rd, err);
      check_slverr(err, 1'b0, $sformatf("write tile %0d", idx));
   endtask

   task automatic tile_read_check(input int idx);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b0, addr_of(idx), '0, rd, err);
      check_slverr(err, 1'b0, $sformatf("read tile %0d", idx));
      check_rdata(rd, word_of(m_shadow[idx]), $sformatf("readback tile %0d", idx));
   endtask

   always @(posedge clk) begin : edge_driver
      logic [31:0] r;
      edge_in_t    e;
      if (drive_edges) begin
         r = rand_word();
         e = r[$bits(edge_in_t)-1:0];
         edge_in <= e;
         hist.push_back(e);
      end
   end

   // samples the same pre-edge values as the DUT
   always @(posedge clk) begin : cycle_model
      logic [1:0] li;
      logic [1:0] ri;
      logic [1:0] ti;
      logic [1:0] bi;
      logic [1:0] nl [TILES];
      logic [1:0] nr [TILES];
      logic [1:0] nt [TILES];
      logic [1:0] nb [TILES];
      logic       nclb [TILES];
      int         r;
      int         c;
      if (reset) begin
         for (int t = 0; t < TILES; t++) begin
            m_cfg[t]    = '0;
            m_shadow[t] = '0;
            m_l[t]      = '0;
            m_r[t]      = '0;
            m_t[t]      = '0;
            m_b[t]      = '0;
            m_clb[t]    = 1'b0;
         end
         pend_en = 1'b0;
      end else begin
         for (int t = 0; t < TILES; t++) begin
            r  = t / COLS;
            c  = t % COLS;
            li = (c == 0) ? edge_in.west[2*r +: 2] : m_r[t-1];
            ri = (c == COLS-1) ? edge_in.east[2*r +: 2] : m_l[t+1];
            ti = (r == 0) ? edge_in.north[2*c +: 2] : m_b[t-COLS];
            bi = (r == ROWS-1) ? edge_in.south[2*c +: 2] : m_t[t+COLS];
            nclb[t]  = logic_op(m_cfg[t].op, cb_pick(m_cfg[t].cb0, ri[0], ri[1]),
                                cb_pick(m_cfg[t].cb1, bi[0], bi[1]));
            nl[t][0] = sb_pick(m_cfg[t].sb.left_0, m_clb[t], ri[0], ti[0]);
            nl[t][1] = sb_pick(m_cfg[t].sb.left_2, m_clb[t], ri[1], ti[1]);
            nr[t][0] = sb_pick(m_cfg[t].sb.right_1, m_clb[t], li[0], bi[0]);
            nr[t][1] = sb_pick(m_cfg[t].sb.right_3, m_clb[t], li[1], bi[1]);
            nt[t][0] = sb_pick(m_cfg[t].sb.top_1, m_clb[t], bi[0], li[0]);
            nt[t][1] = sb_pick(m_cfg[t].sb.top_3, m_clb[t], bi[1], li[1]);
            nb[t][0] = sb_pick(m_cfg[t].sb.bottom_0, m_clb[t], ti[0], ri[0]);
            nb[t][1] = sb_pick(m_cfg[t].sb.bottom_2, m_clb[t], ti[1], ri[1]);
         end
         for (int t = 0; t < TILES; t++) begin
            m_l[t]   = nl[t];
            m_r[t]   = nr[t];
            m_t[t]   = nt[t];
            m_b[t]   = nb[t];
            m_clb[t] = nclb[t];
            if (pend_en && pend_idx == t) begin
               m_cfg[t] = pend_data;   // tile loads on the en cycle
            end
         end
         pend_en = apb_req.psel && apb_req.penable && apb_req.pwrite
                   && addr_valid(apb_req.paddr);
         if (pend_en) begin
            pend_idx           = int'(apb_req.paddr[`TILE_ADDR_WIDTH+1:2]);
            pend_data          = apb_req.pwdata[`TILE_CFG_WIDTH-1:0];
            m_shadow[pend_idx] = pend_data;
         end
      end
   end

   always @(negedge clk) begin
      if (!reset) begin
         check_edge(edge_out, model_edge(), "cycle model");
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0] rd;
      logic        err;
      tile_cfg_t   cfg;
      edge_out_t   exp;
      logic [31:0] reg_word [TILES];
      logic [31:0] bad_word [3];
      logic [31:0] rand_cfg [TILES];
      logic [31:0] rewr_word [3];
      int          rewr_tile [3];
      logic [`APB_ADDR_WIDTH-1:0] bad_wr_addr [3];
      logic [`APB_ADDR_WIDTH-1:0] bad_rd_addr [2];

      seed        = 32'he653_d07c;
      reset       = 1'b1;
      apb_req     = '0;
      drive_edges = 1'b0;
      bad_wr_addr = '{12'h010, 12'h3fc, 12'h400};
      bad_rd_addr = '{12'h014, 12'h800};
      // every random word is drawn before the edge driver starts
      for (int i = 0; i < TILES; i++) begin
         reg_word[i] = rand_word();
         rand_cfg[i] = rand_word();
      end
      for (int i = 0; i < 3; i++) begin
         bad_word[i]  = rand_word();
         rewr_word[i] = rand_word();
         rd           = rand_word();
         rewr_tile[i] = int'(rd[1:0]);
      end

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      @(negedge clk);
      check_edge(edge_out, '0, "after reset");
      check_slverr(apb_rsp.pslverr, 1'b0, "idle after reset");
      for (int i = 0; i < TILES; i++) begin
         apb_transfer(1'b0, addr_of(i), '0, rd, err);
         check_slverr(err, 1'b0, "read after reset");
         check_rdata(rd, 32'h0, $sformatf("tile %0d after reset", i));
      end

      for (int i = 0; i < TILES; i++) begin
         tile_write(i, reg_word[i]);
      end
      for (int i = 0; i < TILES; i++) begin
         tile_read_check(i);
      end
      for (int i = 0; i < 3; i++) begin
         apb_transfer(1'b1, bad_wr_addr[i], bad_word[i], rd, err);
         check_slverr(err, 1'b1, $sformatf("write to %h", bad_wr_addr[i]));
      end
      for (int i = 0; i < 2; i++) begin
         apb_transfer(1'b0, bad_rd_addr[i], '0, rd, err);
         check_slverr(err, 1'b1, $sformatf("read from %h", bad_rd_addr[i]));
         check_rdata(rd, 32'h0, $sformatf("read from %h", bad_rd_addr[i]));
      end
      for (int i = 0; i < TILES; i++) begin
         tile_read_check(i);
      end

      // directed routes into tile 0 with the result leaving on east[0]
      @(posedge clk);
      drive_edges <= 1'b1;
      cfg = '0;
      cfg.sb.top_1 = SB_TURN;
      cfg.sb.top_3 = SB_TURN;
      tile_write(2, word_of(cfg));
      cfg = '0;
      cfg.sb.left_0  = SB_STRAIGHT;
      cfg.sb.left_2  = SB_STRAIGHT;
      cfg.sb.right_1 = SB_STRAIGHT;
      tile_write(1, word_of(cfg));
      tile_write(3, 32'h0);
      for (int o = 0; o < 4; o++) begin
         for (int s = 0; s < 4; s++) begin
            cfg = '0;
            cfg.cb0 = cb_sel_e'(s[1:0]);
            cfg.cb1 = cb_sel_e'(2'(3 - s));
            cfg.op  = clb_op_e'(o[1:0]);
            cfg.sb.right_1 = SB_CLB;
            tile_write(0, word_of(cfg));
            @(negedge clk);
            hist.delete();
            repeat (16) begin
               @(negedge clk);
               if (hist.size() > DIR_HOPS) begin
                  exp = model_edge();
                  exp.east[0] = directed_result(cfg, hist[hist.size()-1-DIR_HOPS]);
                  check_edge(edge_out, exp, $sformatf("directed op %0d sel %0d", o, s));
               end
            end
         end
      end

      for (int i = 0; i < TILES; i++) begin
         tile_write(i, rand_cfg[i]);
      end
      repeat (400) @(posedge clk);

      // rewrites land while the mesh keeps moving data
      for (int i = 0; i < 3; i++) begin
         repeat (20) @(posedge clk);
         tile_write(rewr_tile[i], rewr_word[i]);
      end
      repeat (20) @(posedge clk);
      tile_read_check(rewr_tile[2]);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
fabric_pkg.sv
connect_box.sv
clb.sv
switch_box.sv
pe_tile.sv
config_apb_slave.sv
fabric_top.sv
tb_fabric.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_fabric -f vlog.f -o sim_fabric
./obj_dir/sim_fabric
